/* verilog.f */
hdl/mem_pkg.sv
hdl/addr_gen.sv
hdl/data_mem.sv
hdl/mem_ctrl.sv
hdl/mem_stage.sv
bench/tb_clock.sv
bench/mem_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= mem_stage_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test completed successfully

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# rebuild only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation reads bench/mem_vectors.txt, so it runs from the project root
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/mem_vectors.txt */
// columns, all hex: op base offset store_data expected_load_data expected_fault
// op: 0 nop, 1 lw, 2 lh, 3 lhu, 4 lb, 5 lbu, 6 sw, 7 sh, 8 sb
6 00000100 0000 8badf00d 00000000 0
1 00000100 0000 00000000 8badf00d 0
2 00000100 0002 00000000 ffff8bad 0
3 00000100 0002 00000000 00008bad 0
2 00000100 0000 00000000 fffff00d 0
4 00000100 0003 00000000 ffffff8b 0
5 00000100 0001 00000000 000000f0 0
4 00000100 0000 00000000 0000000d 0
7 00000100 0002 00001234 00000000 0
8 00000100 0001 000000a5 00000000 0
1 00000100 0000 00000000 1234a50d 0
8 00000104 fffc 0000007f 00000000 0
1 00000100 0000 00000000 1234a57f 0
// misaligned accesses
6 00000100 0001 deadbeef 00000000 1
1 00000100 0000 00000000 1234a57f 0
2 00000100 0001 00000000 00000000 1
1 00000102 0000 00000000 00000000 1
7 00000100 0003 0000ffff 00000000 1
1 00000100 0000 00000000 1234a57f 0
// out of range, including a negative offset that underflows
6 00000ffc 0004 11111111 00000000 1
1 00000ffc 0000 00000000 00000000 0
1 00000000 0000 00000000 00000000 0
8 00000002 fffc 00000055 00000000 1
5 00000002 fffe 00000000 00000000 0
1 00000000 fff0 00000000 00000000 1
6 00000ff0 000c cafebabe 00000000 0
1 00001000 fffc 00000000 cafebabe 0
5 00000ffc 0003 00000000 000000ca 0
2 00000ffc 0000 00000000 ffffbabe 0
0 00000100 0000 00000000 00000000 0

/* bench/mem_stage_tb.sv */
module mem_stage_tb;
	import mem_pkg::*;

	localparam int max_vectors = 64;
	localparam int random_count = 200;
	localparam int burst_len = 260;
	localparam int reset_cycles = 8;

	logic        clk;
	logic        rst;
	logic        req;
	mem_op_t     op;
	logic [31:0] base;
	logic [15:0] offset;
	logic [31:0] store_data;
	logic [31:0] pc;
	logic        fault_clear;
	logic [31:0] load_data;
	logic        load_valid;
	logic        fault;
	logic        fault_pending;
	logic [31:0] bad_addr;
	logic [31:0] fault_pc;
	logic [7:0]  fault_count;

	logic [31:0] vec_mem [0:6*max_vectors-1];
	logic [7:0]  shadow [0:4095];	// byte image of the data memory.
	logic [31:0] lcg_state;
	logic [31:0] next_pc;
	int          num_vectors;
	int          watchdog_cycles;
	int          error_count;
	int          check_total;
	int          test_count;
	int          errors_at_start;
	string       test_name;

	// expectations for the request in flight.
	mem_op_t     pend_op;
	mem_mode_t   pend_mode;
	logic        pend_valid;
	logic [31:0] pend_data;
	logic        pend_fault;
	logic        exp_pending;
	logic [7:0]  exp_count;
	logic        seen_fault;
	logic [31:0] exp_bad_addr;
	logic [31:0] exp_fault_pc;
	logic        clear_next;

	tb_clock #(.period(10)) u_clock (.clk(clk));

	mem_stage uut (.*);

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic mem_mode_t op_mode(mem_op_t o);
		case (o)
			op_lw, op_sw: return mode_w;
			op_lh, op_sh: return mode_h;
			op_lhu: return mode_hu;
			op_lb, op_sb: return mode_b;
			op_lbu: return mode_bu;
			default: return mode_none;
		endcase
	endfunction

	function automatic logic is_load_op(mem_op_t o);
		return (o == op_lw) || (o == op_lh) || (o == op_lhu)
			|| (o == op_lb) || (o == op_lbu);
	endfunction

	// little endian with lane 0 at the lowest byte address.
	function automatic logic [31:0] read_shadow(mem_mode_t m, logic [31:0] a);
		logic [11:0] i;
		i = a[11:0];
		case (m)
			mode_w: return {shadow[i + 12'd3], shadow[i + 12'd2],
				shadow[i + 12'd1], shadow[i]};
			mode_h: return {{16{shadow[i + 12'd1][7]}}, shadow[i + 12'd1], shadow[i]};
			mode_hu: return {16'h0, shadow[i + 12'd1], shadow[i]};
			mode_b: return {{24{shadow[i][7]}}, shadow[i]};
			mode_bu: return {24'h0, shadow[i]};
			default: return 32'h0;
		endcase
	endfunction

	task automatic write_shadow(mem_mode_t m, logic [31:0] a, logic [31:0] d);
		logic [11:0] i;
		i = a[11:0];
		shadow[i] = d[7:0];
		if (m == mode_w || m == mode_h) shadow[i + 12'd1] = d[15:8];
		if (m == mode_w) begin
			shadow[i + 12'd2] = d[23:16];
			shadow[i + 12'd3] = d[31:24];
		end
	endtask

	task automatic check_data(string sig, mem_mode_t m, logic [31:0] got, logic [31:0] exp);
		check_total++;
		if (got !== exp) begin
			error_count++;
			$display("ERR %s: got %h expected %h (%s)", sig, got, exp, m.name());
		end
	endtask

	task automatic check_flag(string sig, mem_op_t o, logic got, logic exp);
		check_total++;
		if (got !== exp) begin
			error_count++;
			$display("ERR %s: got %h expected %h (%s)", sig, got, exp, o.name());
		end
	endtask

	task automatic check_count(string sig, logic [7:0] got, logic [7:0] exp);
		check_total++;
		if (got !== exp) begin
			error_count++;
			$display("ERR %s: got %h expected %h", sig, got, exp);
		end
	endtask

	task automatic start_test(string name);
		test_name = name;
		errors_at_start = error_count;
	endtask

	task automatic end_test();
		int errs;
		errs = error_count - errors_at_start;
		test_count++;
		if (errs == 0) $display("test %s: ok", test_name);
		else $display("test %s: %0d errors", test_name, errs);
	endtask

	task automatic check_outputs();
		check_flag("load_valid", pend_op, load_valid, pend_valid);
		if (pend_valid) check_data("load_data", pend_mode, load_data, pend_data);
		check_flag("fault", pend_op, fault, pend_fault);
		check_flag("fault_pending", pend_op, fault_pending, exp_pending);
		check_count("fault_count", fault_count, exp_count);
		if (seen_fault) begin
			check_data("bad_addr", pend_mode, bad_addr, exp_bad_addr);
			check_data("fault_pc", pend_mode, fault_pc, exp_fault_pc);
		end
	endtask

	task automatic go_idle();
		req = 1'b0;
		op = op_nop;
		fault_clear = 1'b0;
		clear_next = 1'b0;
		pend_op = op_nop;
		pend_mode = mode_none;
		pend_valid = 1'b0;
		pend_fault = 1'b0;
	endtask

	// drives one request now and checks it at the next falling edge.
	task automatic send(mem_op_t o, logic [31:0] b, logic [15:0] off, logic [31:0] d,
			logic [31:0] exp_load, logic exp_fault);
		logic [31:0] a;
		a = b + {{16{off[15]}}, off};
		req = 1'b1;
		op = o;
		base = b;
		offset = off;
		store_data = d;
		pc = next_pc;
		fault_clear = clear_next;
		pend_op = o;
		pend_mode = op_mode(o);
		pend_valid = is_load_op(o);
		pend_data = exp_load;
		pend_fault = exp_fault;
		if (exp_fault) begin
			exp_pending = 1'b1;	// a new fault beats a clear.
			seen_fault = 1'b1;
			exp_bad_addr = a;
			exp_fault_pc = next_pc;
			if (exp_count != 8'hff) exp_count = exp_count + 8'd1;
		end else if (clear_next) begin
			exp_pending = 1'b0;
		end
		if (!exp_fault && op_mode(o) != mode_none && !is_load_op(o)) begin
			write_shadow(pend_mode, a, d);
		end
		next_pc = next_pc + 32'd4;
		@(negedge clk);
		check_outputs();
		go_idle();
	endtask

	task automatic idle_cycle();
		fault_clear = clear_next;
		if (clear_next) exp_pending = 1'b0;
		@(negedge clk);
		check_outputs();
		go_idle();
	endtask

	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
		$display("Test failed");
		$finish;
	end

	initial begin
		mem_op_t     vop;
		mem_op_t     rop;
		mem_mode_t   rmode;
		logic [31:0] r;
		logic [31:0] ra;
		logic [15:0] roff;
		rst = 1'b1;
		base = 32'h0;
		offset = 16'h0;
		store_data = 32'h0;
		pc = 32'h0;
		go_idle();
		lcg_state = 32'd47041;
		next_pc = 32'h0040_0000;
		exp_pending = 1'b0;
		exp_count = 8'd0;
		seen_fault = 1'b0;
		exp_bad_addr = 32'h0;
		exp_fault_pc = 32'h0;
		error_count = 0;
		check_total = 0;
		test_count = 0;
		for (int i = 0; i < 4096; i++) shadow[i] = 8'h00;
		for (int i = 0; i < 6 * max_vectors; i++) vec_mem[i] = 32'hffff_ffff;	// end marker.
		$readmemh("bench/mem_vectors.txt", vec_mem);
		num_vectors = 0;
		while (num_vectors < max_vectors
				&& vec_mem[6 * num_vectors] !== 32'hffff_ffff) begin
			num_vectors++;
		end
		if (num_vectors == 0) begin
			error_count++;
			$display("no vectors could be read from bench/mem_vectors.txt");
		end
		watchdog_cycles = 20 * num_vectors + random_count + burst_len + reset_cycles + 100;

		start_test("reset state");
		repeat (reset_cycles) @(negedge clk);
		rst = 1'b0;
		idle_cycle();
		for (int n = 0; n < 16; n++) begin
			r = next_random();
			send(op_lw, {20'h0, r[11:2], 2'b00}, 16'h0, 32'h0, 32'h0, 1'b0);
		end
		idle_cycle();
		end_test();

		for (int v = 0; v < num_vectors; v++) begin
			vop = mem_op_t'(vec_mem[6 * v][3:0]);
			start_test($sformatf("vector %0d %s", v, vop.name()));
			send(vop, vec_mem[6 * v + 1], vec_mem[6 * v + 2][15:0], vec_mem[6 * v + 3],
				vec_mem[6 * v + 4], vec_mem[6 * v + 5][0]);
			idle_cycle();	// load_valid and fault must drop again.
			end_test();
		end

		start_test("back to back");
		send(op_sw, 32'h200, 16'h0, 32'h8765_4321, 32'h0, 1'b0);
		send(op_lw, 32'h200, 16'h0, 32'h0, 32'h8765_4321, 1'b0);
		send(op_lb, 32'h200, 16'h3, 32'h0, 32'hffff_ff87, 1'b0);
		send(op_lhu, 32'h200, 16'h2, 32'h0, 32'h0000_8765, 1'b0);
		send(op_sb, 32'h200, 16'h1, 32'h0000_00ff, 32'h0, 1'b0);
		send(op_lw, 32'h200, 16'h0, 32'h0, 32'h8765_ff21, 1'b0);
		idle_cycle();
		end_test();

		start_test("fault pending");
		repeat (3) idle_cycle();
		clear_next = 1'b1;
		idle_cycle();
		idle_cycle();
		clear_next = 1'b1;
		send(op_sh, 32'h300, 16'h1, 32'h0, 32'h0, 1'b1);
		idle_cycle();
		clear_next = 1'b1;
		idle_cycle();
		end_test();

		start_test("fault count saturation");
		for (int n = 0; n < burst_len; n++) send(op_lw, 32'h400, 16'h2, 32'h0, 32'h0, 1'b1);
		idle_cycle();
		check_count("fault_count", fault_count, 8'hff);
		end_test();

		start_test("random");
		for (int n = 0; n < random_count; n++) begin
			r = next_random();
			rop = mem_op_t'({1'b0, r[30:28]} + 4'd1);
			rmode = op_mode(rop);
			ra = {20'h0, r[11:0]};
			if (rmode == mode_w) ra[1:0] = 2'b00;
			if (rmode == mode_h || rmode == mode_hu) ra[0] = 1'b0;
			roff = {{10{r[17]}}, r[17:12]};
			send(rop, ra - {{16{roff[15]}}, roff}, roff, next_random(),
				is_load_op(rop) ? read_shadow(rmode, ra) : 32'h0, 1'b0);
		end
		idle_cycle();
		end_test();

		$display("tests %0d, checks %0d, errors %0d", test_count, check_total, error_count);
		if (error_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* bench/tb_clock.sv */
module tb_clock #(
	parameter int period = 10
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always begin
		#(period / 2);
		clk = ~clk;
	end

endmodule

/* hdl/mem_stage.sv */
module mem_stage (
	input  logic             clk,
	input  logic             rst,
	input  logic             req,
	input  mem_pkg::mem_op_t op,
	input  logic [31:0]      base,
	input  logic [15:0]      offset,
	input  logic [31:0]      store_data,
	input  logic [31:0]      pc,
	input  logic             fault_clear,
	output logic [31:0]      load_data,
	output logic             load_valid,
	output logic             fault,
	output logic             fault_pending,
	output logic [31:0]      bad_addr,
	output logic [31:0]      fault_pc,
	output logic [7:0]       fault_count
);
	import mem_pkg::*;

	logic [31:0] addr;
	logic        out_of_range;
	mem_mode_t   mode;
	logic        write_enable;
	logic [31:0] read_result;
	logic        misaligned;

	addr_gen u_addr_gen (
		.base         (base),
		.offset       (offset),
		.addr         (addr),
		.out_of_range (out_of_range)
	);

	mem_ctrl u_mem_ctrl (
		.clk           (clk),
		.rst           (rst),
		.req           (req),
		.op            (op),
		.pc            (pc),
		.addr          (addr),
		.out_of_range  (out_of_range),
		.misaligned    (misaligned),
		.read_result   (read_result),
		.fault_clear   (fault_clear),
		.mode          (mode),
		.write_enable  (write_enable),
		.load_data     (load_data),
		.load_valid    (load_valid),
		.fault         (fault),
		.fault_pending (fault_pending),
		.bad_addr      (bad_addr),
		.fault_pc      (fault_pc),
		.fault_count   (fault_count)
	);

	data_mem u_data_mem (
		.clk          (clk),
		.rst          (rst),
		.addr         (addr),
		.mode         (mode),
		.write_enable (write_enable),
		.write_data   (store_data),
		.read_result  (read_result),
		.misaligned   (misaligned)
	);

endmodule

/* hdl/mem_ctrl.sv */
module mem_ctrl (
	input  logic               clk,
	input  logic               rst,
	input  logic               req,
	input  mem_pkg::mem_op_t   op,
	input  logic [31:0]        pc,
	input  logic [31:0]        addr,
	input  logic               out_of_range,
	input  logic               misaligned,
	input  logic [31:0]        read_result,
	input  logic               fault_clear,
	output mem_pkg::mem_mode_t mode,
	output logic               write_enable,
	output logic [31:0]        load_data,
	output logic               load_valid,
	output logic               fault,
	output logic               fault_pending,
	output logic [31:0]        bad_addr,
	output logic [31:0]        fault_pc,
	output logic [7:0]         fault_count
);
	import mem_pkg::*;

	logic is_load;
	logic is_store;
	logic access_bad;
	logic fault_now;

	// opcode decode.
	always_comb begin
		mode = mode_none;
		is_load = 1'b0;
		is_store = 1'b0;
		case (op)
			op_lw: begin
				mode = mode_w;
				is_load = 1'b1;
			end
			op_lh: begin
				mode = mode_h;
				is_load = 1'b1;
			end
			op_lhu: begin
				mode = mode_hu;
				is_load = 1'b1;
			end
			op_lb: begin
				mode = mode_b;
				is_load = 1'b1;
			end
			op_lbu: begin
				mode = mode_bu;
				is_load = 1'b1;
			end
			op_sw: begin
				mode = mode_w;
				is_store = 1'b1;
			end
			op_sh: begin
				mode = mode_h;
				is_store = 1'b1;
			end
			op_sb: begin
				mode = mode_b;
				is_store = 1'b1;
			end
			default: begin
				mode = mode_none;	// op_nop.
			end
		endcase
	end

	assign write_enable = req && is_store && !out_of_range;	// memory drops misaligned ones.

	assign access_bad = misaligned || out_of_range;
	assign fault_now = req && (op != op_nop) && access_bad;

	always_ff @(posedge clk) begin
		if (rst) begin
			load_valid <= 1'b0;
		end else begin
			load_valid <= req && is_load;
		end
	end

	// a faulting load hands back zero.
	always_ff @(posedge clk) begin
		if (req && is_load) begin
			load_data <= access_bad ? 32'b0 : read_result;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			fault <= 1'b0;
			fault_pending <= 1'b0;
		end else begin
			fault <= fault_now;
			if (fault_now) begin
				fault_pending <= 1'b1;	// new fault beats a clear.
			end else if (fault_clear) begin
				fault_pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fault_now) begin
			bad_addr <= addr;
			fault_pc <= pc;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			fault_count <= 8'd0;
		end else if (fault_now && (fault_count != 8'hff)) begin
			fault_count <= fault_count + 8'd1;	// saturates at 255.
		end
	end

endmodule

/* hdl/data_mem.sv */
module data_mem (
	input  logic               clk,
	input  logic               rst,
	input  logic [31:0]        addr,
	input  mem_pkg::mem_mode_t mode,
	input  logic               write_enable,
	input  logic [31:0]        write_data,
	output logic [31:0]        read_result,
	output logic               misaligned
);
	import mem_pkg::*;

	logic [31:0] memory [dm_words];

	logic [dm_addr_width-3:0] word_idx;
	logic [1:0]               lane;
	logic [31:0]              cur_word;
	logic [3:0]               byte_en;
	logic [31:0]              lane_data;
	logic [31:0]              new_word;
	logic [15:0]              half_sel;
	logic [7:0]               byte_sel;

	assign word_idx = addr[dm_addr_width-1:2];
	assign lane = addr[1:0];
	assign cur_word = memory[word_idx];	// one port serves reads and writes.

	// alignment check.
	always_comb begin
		case (mode)
			mode_w: begin
				misaligned = (lane != 2'b00);
			end
			mode_h, mode_hu: begin
				misaligned = lane[0];
			end
			default: begin
				misaligned = 1'b0;	// bytes and none are always aligned.
			end
		endcase
	end

	// byte lanes touched by a store and the data replicated across them.
	always_comb begin
		byte_en = 4'b0000;
		lane_data = 32'b0;
		case (mode)
			mode_w: begin
				byte_en = 4'b1111;
				lane_data = write_data;
			end
			mode_h: begin
				byte_en = lane[1] ? 4'b1100 : 4'b0011;
				lane_data = {2{write_data[15:0]}};
			end
			mode_b: begin
				byte_en = 4'b0001 << lane;
				lane_data = {4{write_data[7:0]}};
			end
			default: begin
				byte_en = 4'b0000;
			end
		endcase
		if (misaligned) begin
			byte_en = 4'b0000;	// misaligned store leaves the word alone.
		end
	end

	// merge the new lanes into the old word.
	always_comb begin
		for (int k = 0; k < 4; k++) begin
			new_word[8*k +: 8] = byte_en[k] ? lane_data[8*k +: 8] : cur_word[8*k +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < dm_words; i++) begin
				memory[i] <= 32'b0;
			end
		end else if (write_enable && (byte_en != 4'b0000)) begin
			memory[word_idx] <= new_word;
		end
	end

	// load lane selection.
	assign half_sel = lane[1] ? cur_word[31:16] : cur_word[15:0];
	assign byte_sel = cur_word[{lane, 3'b000} +: 8];

	always_comb begin
		read_result = 32'b0;
		if (!misaligned) begin
			case (mode)
				mode_w: begin
					read_result = cur_word;
				end
				mode_h: begin
					read_result = {{16{half_sel[15]}}, half_sel};
				end
				mode_hu: begin
					read_result = {16'b0, half_sel};
				end
				mode_b: begin
					read_result = {{24{byte_sel[7]}}, byte_sel};
				end
				mode_bu: begin
					read_result = {24'b0, byte_sel};
				end
				default: begin
					read_result = 32'b0;	// mode_none.
				end
			endcase
		end
	end

endmodule

/* hdl/addr_gen.sv */
module addr_gen (
	input  logic [31:0] base,
	input  logic [15:0] offset,
	output logic [31:0] addr,
	output logic        out_of_range
);
	import mem_pkg::*;

	logic [31:0] offset_ext;

	assign offset_ext = {{16{offset[15]}}, offset};	// sign extend the immediate.

	assign addr = base + offset_ext;

	// anything above the decoded bits lies outside the memory.
	// a negative offset that underflows wraps high and lands here too.
	assign out_of_range = |addr[31:dm_addr_width];

endmodule

/* hdl/mem_pkg.sv */
package mem_pkg;

	// data memory geometry.
	localparam int dm_addr_width = 12;	// byte address bits, 4 KiB.
	localparam int dm_words = 1024;	// 32-bit words.

	// load/store opcodes seen by the memory stage.
	typedef enum logic [3:0] {
		op_nop,
		op_lw,
		op_lh,
		op_lhu,
		op_lb,
		op_lbu,
		op_sw,
		op_sh,
		op_sb
	} mem_op_t;

	// access width and extension for the data memory.
	// stores only use mode_w, mode_h and mode_b.
	typedef enum logic [2:0] {
		mode_none,
		mode_w,	// full word.
		mode_h,	// halfword, sign extended.
		mode_hu,	// halfword, zero extended.
		mode_b,	// byte, sign extended.
		mode_bu	// byte, zero extended.
	} mem_mode_t;

endpackage
